// ==== hdl/periph_bus_pkg.sv ====
`include "periph_cfg.svh"

package periph_bus_pkg;

    // Byte address, slot in bits 15..12 and word offset in bits 5..2
    typedef struct packed {
        logic [`PERIPH_SLOT_W-1:0]                                   slot;
        logic [`PERIPH_ADDR_W-`PERIPH_SLOT_W-`PERIPH_OFS_W-2-1:0]    unused;
        logic [`PERIPH_OFS_W-1:0]                                    ofs;
        logic [1:0]                                                  byte_sel;
    } addr_t;

    // One register access, always a full word
    typedef struct packed {
        logic                       write;
        addr_t                      addr;
        logic [`PERIPH_DATA_W-1:0]  wdata;
    } req_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } resp_e;

    // Response beat, valid for one cycle
    typedef struct packed {
        logic                       valid;
        resp_e                      resp;
        logic [`PERIPH_DATA_W-1:0]  rdata;
    } rsp_t;

endpackage

// ==== hdl/periph_cfg.svh ====
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// ------------------------------------------------------------
// Bus geometry
// ------------------------------------------------------------
`define PERIPH_DATA_W      32
`define PERIPH_ADDR_W      16
`define PERIPH_SLOT_W      4
`define PERIPH_OFS_W       4

// Request queue depth, equal to the requester's initial credits
`define PERIPH_REQ_CREDITS 4

// Peripheral sizing
`define PERIPH_TIMER_CNT   2
`define PERIPH_NUM_SRC     4
`define PERIPH_PRIO_W      3

// Address slots
`define PERIPH_SLOT_IRQ    0
`define PERIPH_SLOT_TIMER  1

`endif

// ==== hdl/periph_decoder.sv ====
`include "periph_cfg.svh"

module periph_decoder (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       pop_i,
    input  periph_bus_pkg::req_t       pop_req_i,
    output logic                       sel_timer_o,
    output logic                       sel_irq_o,
    output logic                       wr_o,
    output logic [`PERIPH_OFS_W-1:0]   ofs_o,
    output logic [`PERIPH_DATA_W-1:0]  wdata_o,
    input  logic [`PERIPH_DATA_W-1:0]  timer_rdata_i,
    input  logic [`PERIPH_DATA_W-1:0]  irq_rdata_i,
    output periph_bus_pkg::rsp_t       rsp_o
);

    logic [`PERIPH_SLOT_W-1:0]  slot;
    logic                       hit_timer;
    logic                       hit_irq;
    periph_bus_pkg::resp_e      resp_d;
    periph_bus_pkg::resp_e      resp_q;
    logic [`PERIPH_DATA_W-1:0]  rdata_d;
    logic [`PERIPH_DATA_W-1:0]  rdata_q;
    logic                       valid_q;

    // ------------------------------------------------------------
    // Slot decode and target strobes
    // ------------------------------------------------------------
    assign slot      = pop_req_i.addr.slot;
    assign hit_timer = (slot == `PERIPH_SLOT_W'(`PERIPH_SLOT_TIMER));
    assign hit_irq   = (slot == `PERIPH_SLOT_W'(`PERIPH_SLOT_IRQ));

    assign sel_timer_o = pop_i && hit_timer;
    assign sel_irq_o   = pop_i && hit_irq;
    assign wr_o        = pop_i && pop_req_i.write;
    assign ofs_o       = pop_req_i.addr.ofs;
    assign wdata_o     = pop_req_i.wdata;

    // ------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------
    always_comb begin
        resp_d  = periph_bus_pkg::OKAY;
        rdata_d = '0;
        if (hit_timer) begin
            if (!pop_req_i.write) begin
                rdata_d = timer_rdata_i;
            end
        end else if (hit_irq) begin
            if (!pop_req_i.write) begin
                rdata_d = irq_rdata_i;
            end
        end else begin
            // Empty slot acts as the shared error slave
            resp_d  = periph_bus_pkg::SLVERR;
            rdata_d = 32'hDEADBEEF;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_i) begin
            resp_q  <= resp_d;
            rdata_q <= rdata_d;
        end
    end

    assign rsp_o = '{valid: valid_q, resp: resp_q, rdata: rdata_q};

endmodule

// ==== hdl/periph_irq_ctrl.sv ====
`include "periph_cfg.svh"

module periph_irq_ctrl (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        sel_i,
    input  logic                        wr_i,
    input  logic [`PERIPH_OFS_W-1:0]    ofs_i,
    input  logic [`PERIPH_DATA_W-1:0]   wdata_i,
    input  logic [`PERIPH_NUM_SRC-1:0]  src_i,
    output logic [`PERIPH_DATA_W-1:0]   rdata_o,
    output logic                        irq_o
);

    localparam int id_w = $clog2(`PERIPH_NUM_SRC + 1);

    // Register map above the per-source priorities
    localparam logic [`PERIPH_OFS_W-1:0] ofs_enable  = 4;
    localparam logic [`PERIPH_OFS_W-1:0] ofs_thresh  = 5;
    localparam logic [`PERIPH_OFS_W-1:0] ofs_pending = 6;
    localparam logic [`PERIPH_OFS_W-1:0] ofs_claim   = 7;

    periph_regs_pkg::prio_t       prio_q [`PERIPH_NUM_SRC];
    periph_regs_pkg::prio_t       thr_q;
    periph_regs_pkg::prio_t       best_prio;
    logic [`PERIPH_NUM_SRC-1:0]   en_q;
    logic [id_w-1:0]              claim_id;
    logic                         wr_en;

    assign wr_en = sel_i && wr_i;

    // ------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            en_q  <= '0;
            thr_q <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
                if (ofs_i == `PERIPH_OFS_W'(i)) begin
                    prio_q[i] <= wdata_i[`PERIPH_PRIO_W-1:0];
                end
            end
            if (ofs_i == ofs_enable) begin
                en_q <= wdata_i[`PERIPH_NUM_SRC-1:0];
            end
            if (ofs_i == ofs_thresh) begin
                thr_q <= wdata_i[`PERIPH_PRIO_W-1:0];
            end
        end
    end

    // ------------------------------------------------------------
    // Claim, strict compare keeps the lower index on a tie
    // ------------------------------------------------------------
    always_comb begin
        best_prio = thr_q;
        claim_id  = '0;
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            if (src_i[i] && en_q[i] && (prio_q[i] > best_prio)) begin
                best_prio = prio_q[i];
                claim_id  = id_w'(i + 1);
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            if (ofs_i == `PERIPH_OFS_W'(i)) begin
                rdata_o = `PERIPH_DATA_W'(prio_q[i]);
            end
        end
        case (ofs_i)
            ofs_enable:  rdata_o = `PERIPH_DATA_W'(en_q);
            ofs_thresh:  rdata_o = `PERIPH_DATA_W'(thr_q);
            ofs_pending: rdata_o = `PERIPH_DATA_W'(src_i);
            ofs_claim:   rdata_o = `PERIPH_DATA_W'(claim_id);
            default: ;
        endcase
    end

    // Target line, one cycle behind sources and registers
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= (claim_id != '0);
        end
    end

endmodule

// ==== hdl/periph_regs_pkg.sv ====
`include "periph_cfg.svh"

package periph_regs_pkg;

    // Timer register word, raw for count and compare, fields for control
    typedef union packed {
        logic [`PERIPH_DATA_W-1:0] raw;
        struct packed {
            logic [`PERIPH_DATA_W-3:0] rsvd;
            logic                      irq_en;
            logic                      enable;
        } ctrl;
    } timer_word_u;

    typedef logic [`PERIPH_PRIO_W-1:0] prio_t;

    // Interrupt source positions
    localparam int SRC_TIMER0 = 0;
    localparam int SRC_TIMER1 = 1;
    localparam int SRC_EXT0   = 2;
    localparam int SRC_EXT1   = 3;

endpackage

// ==== hdl/periph_req_queue.sv ====
`include "periph_cfg.svh"

module periph_req_queue (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  req_valid_i,
    input  periph_bus_pkg::req_t  req_i,
    output logic                  credit_o,
    output logic                  pop_o,
    output periph_bus_pkg::req_t  pop_req_o
);

    localparam int depth  = `PERIPH_REQ_CREDITS;
    localparam int ptr_w  = $clog2(depth);
    localparam int fill_w = ptr_w + 1;

    periph_bus_pkg::req_t mem_q [depth];
    logic [ptr_w-1:0]     wr_ptr_q;
    logic [ptr_w-1:0]     rd_ptr_q;
    logic [fill_w-1:0]    fill_q;
    logic                 deq;

    // Drain one entry per cycle while anything is stored
    assign deq = (fill_q != '0);

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            mem_q[wr_ptr_q] <= req_i;
        end
        if (deq) begin
            pop_req_o <= mem_q[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
            pop_o    <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            fill_q <= fill_q + fill_w'(req_valid_i) - fill_w'(deq);
            pop_o  <= deq;
        end
    end

    // Every pop frees one slot, hand it back to the requester
    assign credit_o = pop_o;

endmodule

// ==== hdl/periph_subsys.sv ====
`include "periph_cfg.svh"

module periph_subsys (
    input  logic                                          clk_i,
    input  logic                                          arst_n_i,
    input  logic                                          req_valid_i,
    input  periph_bus_pkg::req_t                          req_i,
    output logic                                          credit_o,
    output periph_bus_pkg::rsp_t                          rsp_o,
    input  logic [`PERIPH_NUM_SRC-`PERIPH_TIMER_CNT-1:0]  ext_irq_i,
    output logic                                          irq_o
);

    logic                          pop;
    periph_bus_pkg::req_t          pop_req;
    logic                          sel_timer;
    logic                          sel_irq;
    logic                          wr;
    logic [`PERIPH_OFS_W-1:0]      ofs;
    logic [`PERIPH_DATA_W-1:0]     wdata;
    logic [`PERIPH_DATA_W-1:0]     timer_rdata;
    logic [`PERIPH_DATA_W-1:0]     irq_rdata;
    logic [`PERIPH_TIMER_CNT-1:0]  timer_irq;
    logic [`PERIPH_NUM_SRC-1:0]    irq_src;

    // Interrupt source map
    assign irq_src[periph_regs_pkg::SRC_TIMER0] = timer_irq[0];
    assign irq_src[periph_regs_pkg::SRC_TIMER1] = timer_irq[1];
    assign irq_src[periph_regs_pkg::SRC_EXT0]   = ext_irq_i[0];
    assign irq_src[periph_regs_pkg::SRC_EXT1]   = ext_irq_i[1];

    periph_req_queue i_req_queue (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .req_valid_i ( req_valid_i ),
        .req_i       ( req_i       ),
        .credit_o    ( credit_o    ),
        .pop_o       ( pop         ),
        .pop_req_o   ( pop_req     )
    );

    periph_decoder i_decoder (
        .clk_i         ( clk_i       ),
        .arst_n_i      ( arst_n_i    ),
        .pop_i         ( pop         ),
        .pop_req_i     ( pop_req     ),
        .sel_timer_o   ( sel_timer   ),
        .sel_irq_o     ( sel_irq     ),
        .wr_o          ( wr          ),
        .ofs_o         ( ofs         ),
        .wdata_o       ( wdata       ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   ),
        .rsp_o         ( rsp_o       )
    );

    periph_timer i_timer (
        .clk_i    ( clk_i       ),
        .arst_n_i ( arst_n_i    ),
        .sel_i    ( sel_timer   ),
        .wr_i     ( wr          ),
        .ofs_i    ( ofs         ),
        .wdata_i  ( wdata       ),
        .rdata_o  ( timer_rdata ),
        .irq_o    ( timer_irq   )
    );

    periph_irq_ctrl i_irq_ctrl (
        .clk_i    ( clk_i     ),
        .arst_n_i ( arst_n_i  ),
        .sel_i    ( sel_irq   ),
        .wr_i     ( wr        ),
        .ofs_i    ( ofs       ),
        .wdata_i  ( wdata     ),
        .src_i    ( irq_src   ),
        .rdata_o  ( irq_rdata ),
        .irq_o    ( irq_o     )
    );

endmodule

// ==== hdl/periph_timer.sv ====
`include "periph_cfg.svh"

module periph_timer (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         sel_i,
    input  logic                         wr_i,
    input  logic [`PERIPH_OFS_W-1:0]     ofs_i,
    input  logic [`PERIPH_DATA_W-1:0]    wdata_i,
    output logic [`PERIPH_DATA_W-1:0]    rdata_o,
    output logic [`PERIPH_TIMER_CNT-1:0] irq_o
);

    periph_regs_pkg::timer_word_u wdata_u;
    periph_regs_pkg::timer_word_u rd_u;
    logic [`PERIPH_DATA_W-1:0]    cnt_q [`PERIPH_TIMER_CNT];
    logic [`PERIPH_DATA_W-1:0]    cmp_q [`PERIPH_TIMER_CNT];
    logic [`PERIPH_TIMER_CNT-1:0] en_q;
    logic [`PERIPH_TIMER_CNT-1:0] irq_en_q;
    logic                         wr_en;

    assign wdata_u.raw = wdata_i;
    assign wr_en       = sel_i && wr_i;

    // Channel t occupies offsets 3t (count), 3t+1 (control), 3t+2 (compare)
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int t = 0; t < `PERIPH_TIMER_CNT; t++) begin
                cnt_q[t] <= '0;
                cmp_q[t] <= '0;
            end
            en_q     <= '0;
            irq_en_q <= '0;
        end else begin
            for (int t = 0; t < `PERIPH_TIMER_CNT; t++) begin
                // A count write reloads and wins over the increment
                if (wr_en && ofs_i == `PERIPH_OFS_W'(3 * t)) begin
                    cnt_q[t] <= wdata_u.raw;
                end else if (en_q[t]) begin
                    cnt_q[t] <= cnt_q[t] + 1'b1;
                end
                if (wr_en && ofs_i == `PERIPH_OFS_W'(3 * t + 1)) begin
                    en_q[t]     <= wdata_u.ctrl.enable;
                    irq_en_q[t] <= wdata_u.ctrl.irq_en;
                end
                if (wr_en && ofs_i == `PERIPH_OFS_W'(3 * t + 2)) begin
                    cmp_q[t] <= wdata_u.raw;
                end
            end
        end
    end

    // Read mux, unmapped offsets return zero
    always_comb begin
        rd_u.raw = '0;
        for (int t = 0; t < `PERIPH_TIMER_CNT; t++) begin
            if (ofs_i == `PERIPH_OFS_W'(3 * t)) begin
                rd_u.raw = cnt_q[t];
            end else if (ofs_i == `PERIPH_OFS_W'(3 * t + 1)) begin
                rd_u.ctrl.enable = en_q[t];
                rd_u.ctrl.irq_en = irq_en_q[t];
            end else if (ofs_i == `PERIPH_OFS_W'(3 * t + 2)) begin
                rd_u.raw = cmp_q[t];
            end
        end
        rdata_o = rd_u.raw;
    end

    // Level interrupt, holds until compare or count moves
    always_comb begin
        for (int t = 0; t < `PERIPH_TIMER_CNT; t++) begin
            irq_o[t] = irq_en_q[t] && (cnt_q[t] >= cmp_q[t]);
        end
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/periph_bus_pkg.sv
hdl/periph_regs_pkg.sv
hdl/periph_req_queue.sv
hdl/periph_decoder.sv
hdl/periph_timer.sv
hdl/periph_irq_ctrl.sv
hdl/periph_subsys.sv
tb/tb_clk_gen.sv
tb/periph_subsys_chk.sv
tb/tb_periph_monitor.sv
tb/tb_periph_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_periph_subsys \
    -f project.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -x "PASS: all tests" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb/periph_subsys_chk.sv ====
`include "periph_cfg.svh"

module periph_subsys_chk (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input logic                 req_valid_i,
    input logic                 credit_i,
    input periph_bus_pkg::rsp_t rsp_i
);

    localparam int depth = `PERIPH_REQ_CREDITS;

    int fill;
    int err_cnt = 0;

    // Shadow of the queue occupancy, one drain per cycle while non-empty
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill <= 0;
        end else begin
            fill <= fill + (req_valid_i ? 1 : 0) - ((fill != 0) ? 1 : 0);
        end
    end

    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) req_valid_i |-> (fill < depth))
        else begin
            $error("request pushed into a full queue");
            err_cnt++;
        end

    // A credit only comes back in the cycle after a stored entry left
    credit_needs_pop: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) credit_i |-> $past(fill != 0))
        else begin
            $error("credit returned in a cycle without a pop");
            err_cnt++;
        end

    // Response one cycle behind the pop of a stored entry
    rsp_after_pop: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) rsp_i.valid |-> $past(fill != 0, 2))
        else begin
            $error("response valid without a pop one cycle earlier");
            err_cnt++;
        end

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held over the first two rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

// ==== tb/tb_periph_monitor.sv ====
`include "periph_cfg.svh"

module tb_periph_monitor (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input logic                 credit_i,
    input periph_bus_pkg::rsp_t rsp_i
);

    // Register copies kept by the model
    logic [`PERIPH_PRIO_W-1:0]  m_prio [`PERIPH_NUM_SRC];
    logic [`PERIPH_NUM_SRC-1:0] m_en;
    logic [`PERIPH_PRIO_W-1:0]  m_thr;
    logic [1:0]                 m_ctrl [`PERIPH_TIMER_CNT];
    logic [31:0]                m_cmp [`PERIPH_TIMER_CNT];

    string       name_q [$];
    logic [1:0]  resp_q [$];
    logic [31:0] data_q [$];
    logic [31:0] mask_q [$];

    int          push_cnt = 0;
    int          rsp_cnt = 0;
    int          credits_back = 0;
    int          err_cnt = 0;
    int          test_err = 0;
    int          test_cnt = 0;
    int          pass_cnt = 0;
    logic [31:0] last_rdata = '0;

    initial begin
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            m_prio[i] = '0;
        end
        for (int t = 0; t < `PERIPH_TIMER_CNT; t++) begin
            m_ctrl[t] = '0;
            m_cmp[t] = '0;
        end
        m_en = '0;
        m_thr = '0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch %s: expected %h, actual %h", name, exp, act);
        err_cnt++;
        test_err++;
    endtask

    task automatic report_failure(input string msg);
        $display("error: %s", msg);
        err_cnt++;
        test_err++;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_err);
        end
        test_err = 0;
    endtask

    // Enabled pending source with the highest priority above threshold
    function automatic logic [31:0] model_claim(input logic [`PERIPH_NUM_SRC-1:0] src);
        int best;
        int id;
        best = int'(m_thr);
        id = 0;
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            if (src[i] && m_en[i] && int'(m_prio[i]) > best) begin
                best = int'(m_prio[i]);
                id = i + 1;
            end
        end
        return 32'(id);
    endfunction

    // ------------------------------------------------------------
    // Model update and expected response for one request
    // ------------------------------------------------------------
    task automatic expect_request(input string name, input periph_bus_pkg::req_t r);
        logic [1:0]  exp_r;
        logic [31:0] exp_d;
        logic [31:0] mask;
        int          ofs;
        int          ch;
        int          kind;
        exp_r = 2'd0;
        exp_d = '0;
        mask = '1;
        ofs = int'(r.addr.ofs);
        ch = ofs / 3;
        kind = ofs % 3;
        if (r.addr.slot == `PERIPH_SLOT_IRQ) begin
            if (r.write) begin
                if (ofs < `PERIPH_NUM_SRC) begin
                    m_prio[ofs] = r.wdata[`PERIPH_PRIO_W-1:0];
                end else if (ofs == 4) begin
                    m_en = r.wdata[`PERIPH_NUM_SRC-1:0];
                end else if (ofs == 5) begin
                    m_thr = r.wdata[`PERIPH_PRIO_W-1:0];
                end
            end else if (ofs < `PERIPH_NUM_SRC) begin
                exp_d = 32'(m_prio[ofs]);
            end else if (ofs == 4) begin
                exp_d = 32'(m_en);
            end else if (ofs == 5) begin
                exp_d = 32'(m_thr);
            end else if (ofs == 6 || ofs == 7) begin
                // Pending and claim follow live levels, checked by the test itself
                mask = '0;
            end
        end else if (r.addr.slot == `PERIPH_SLOT_TIMER) begin
            if (ch < `PERIPH_TIMER_CNT) begin
                if (r.write) begin
                    if (kind == 1) m_ctrl[ch] = r.wdata[1:0];
                    if (kind == 2) m_cmp[ch] = r.wdata;
                end else if (kind == 0) begin
                    mask = '0;
                end else if (kind == 1) begin
                    exp_d = {30'b0, m_ctrl[ch]};
                end else begin
                    exp_d = m_cmp[ch];
                end
            end
        end else begin
            exp_r = 2'd2;
            exp_d = 32'hDEADBEEF;
        end
        name_q.push_back(name);
        resp_q.push_back(exp_r);
        data_q.push_back(exp_d);
        mask_q.push_back(mask);
        push_cnt++;
    endtask

    // Outputs are compared away from the rising edge
    always @(negedge clk_i) begin
        string       name;
        logic [1:0]  act_r;
        logic [31:0] mask;
        logic [31:0] exp_d;
        if (arst_n_i) begin
            if (credit_i) begin
                credits_back++;
                if (credits_back > push_cnt) begin
                    report_failure("credit returned with no request outstanding");
                end
            end
            if (rsp_i.valid) begin
                rsp_cnt++;
                if (name_q.size() == 0) begin
                    report_failure("response arrived with no request outstanding");
                end else begin
                    name = name_q.pop_front();
                    act_r = rsp_i.resp;
                    exp_d = data_q.pop_front();
                    mask = mask_q.pop_front();
                    if (act_r !== resp_q[0]) begin
                        report_mismatch({name, " resp"}, 32'(resp_q[0]), 32'(act_r));
                    end
                    void'(resp_q.pop_front());
                    if ((rsp_i.rdata & mask) !== exp_d) begin
                        report_mismatch(name, exp_d, rsp_i.rdata);
                    end
                    last_rdata = rsp_i.rdata;
                end
            end
        end
    end

endmodule

// ==== tb/tb_periph_subsys.sv ====
`include "periph_cfg.svh"

module tb_periph_subsys;

    localparam int credits_max = `PERIPH_REQ_CREDITS;
    localparam int num_req     = 133;
    localparam int limit_time  = num_req * (credits_max + 4) * 8 + 2000;

    logic                 clk;
    logic                 arst_n;
    logic                 req_valid;
    periph_bus_pkg::req_t req;
    logic                 credit;
    periph_bus_pkg::rsp_t rsp;
    logic [1:0]           ext_irq;
    logic                 irq;
    int                   seed;
    int                   sent;
    int                   total_err;

    tb_clk_gen u_clk (
        .clk_o    ( clk    ),
        .arst_n_o ( arst_n )
    );

    periph_subsys UUT (
        .clk_i       ( clk       ),
        .arst_n_i    ( arst_n    ),
        .req_valid_i ( req_valid ),
        .req_i       ( req       ),
        .credit_o    ( credit    ),
        .rsp_o       ( rsp       ),
        .ext_irq_i   ( ext_irq   ),
        .irq_o       ( irq       )
    );

    tb_periph_monitor u_mon (
        .clk_i    ( clk    ),
        .arst_n_i ( arst_n ),
        .credit_i ( credit ),
        .rsp_i    ( rsp    )
    );

    bind periph_subsys periph_subsys_chk u_chk (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .req_valid_i ( req_valid_i ),
        .credit_i    ( credit_o    ),
        .rsp_i       ( rsp_o       )
    );

    // Issue one request once a credit is held, called just after an edge
    task automatic send(input string name, input logic wr, input int slot,
                        input int ofs, input logic [31:0] data);
        periph_bus_pkg::req_t r;
        r = '0;
        r.write = wr;
        r.addr.slot = 4'(slot);
        r.addr.ofs = 4'(ofs);
        r.wdata = data;
        while (sent - u_mon.credits_back >= credits_max) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req = r;
        u_mon.expect_request(name, r);
        sent++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (u_mon.rsp_cnt < sent) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_word(input string name, input int slot, input int ofs,
                             output logic [31:0] d);
        send(name, 1'b0, slot, ofs, '0);
        drain();
        d = u_mon.last_rdata;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Timer offsets holding control or compare, 1 2 4 5
    function automatic int timer_cfg_ofs(input int k);
        return k + k / 2 + 1;
    endfunction

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------
    initial begin
        #(limit_time);
        $display("timeout: run did not finish within %0d time units", limit_time);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] d;
        logic [31:0] c1;
        logic [31:0] c2;
        logic [31:0] exp_claim;
        int          ofs;
        seed = 55;
        sent = 0;
        req_valid = 1'b0;
        req = '0;
        ext_irq = 2'b00;
        wait (arst_n);
        wait_cycles(1);

        // Register write and read back
        for (int i = 0; i < 8; i++) begin
            ofs = int'($unsigned($random(seed)) % 6);
            send("reg_rw", 1'b1, `PERIPH_SLOT_IRQ, ofs, $random(seed));
            send("reg_rw", 1'b0, `PERIPH_SLOT_IRQ, ofs, '0);
            ofs = timer_cfg_ofs(int'($unsigned($random(seed)) % 4));
            send("reg_rw", 1'b1, `PERIPH_SLOT_TIMER, ofs, $random(seed));
            send("reg_rw", 1'b0, `PERIPH_SLOT_TIMER, ofs, '0);
        end
        drain();
        u_mon.finish_test("reg_rw");

        // Empty slots and unmapped writes
        for (int i = 0; i < 10; i++) begin
            send("err_slot", 1'($random(seed)), 2 + int'($unsigned($random(seed)) % 14),
                 int'($unsigned($random(seed)) % 16), $random(seed));
            send("err_slot", 1'b1, `PERIPH_SLOT_TIMER,
                 6 + int'($unsigned($random(seed)) % 10), $random(seed));
        end
        drain();
        u_mon.finish_test("err_slot");

        // Back to back reads limited by credits only
        for (int i = 0; i < 16; i++) begin
            case (int'($unsigned($random(seed)) % 3))
                0: send("back_to_back", 1'b0, `PERIPH_SLOT_IRQ,
                        int'($unsigned($random(seed)) % 6), '0);
                1: send("back_to_back", 1'b0, `PERIPH_SLOT_TIMER,
                        timer_cfg_ofs(int'($unsigned($random(seed)) % 4)), '0);
                default: send("back_to_back", 1'b0, 2, 0, '0);
            endcase
        end
        drain();
        wait_cycles(2);
        if (credits_max - sent + u_mon.credits_back != credits_max) begin
            u_mon.report_failure("credits did not return to the full count");
        end
        if (u_mon.rsp_cnt != u_mon.push_cnt) begin
            u_mon.report_failure("request count differs from response count");
        end
        u_mon.finish_test("back_to_back");

        // Timer 0 counting and compare interrupt
        send("timer", 1'b1, `PERIPH_SLOT_TIMER, 0, 32'd0);
        send("timer", 1'b1, `PERIPH_SLOT_TIMER, 2, 32'd20);
        send("timer", 1'b1, `PERIPH_SLOT_TIMER, 1, 32'd1);
        read_word("timer", `PERIPH_SLOT_TIMER, 0, c1);
        wait_cycles(3);
        read_word("timer", `PERIPH_SLOT_TIMER, 0, c2);
        if (c2 <= c1) begin
            u_mon.report_failure("timer count did not increase between reads");
        end
        wait_cycles(30);
        send("timer", 1'b1, `PERIPH_SLOT_TIMER, 1, 32'd3);
        wait_cycles(3);
        read_word("timer", `PERIPH_SLOT_IRQ, 6, d);
        if (d[0] !== 1'b1) begin
            u_mon.report_mismatch("timer", 32'd1, 32'(d[0]));
        end
        u_mon.finish_test("timer");

        // Claim and target line with timer sources held low
        send("irq_claim", 1'b1, `PERIPH_SLOT_TIMER, 1, 32'd0);
        send("irq_claim", 1'b1, `PERIPH_SLOT_TIMER, 4, 32'd0);
        for (int i = 0; i < 8; i++) begin
            for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
                send("irq_claim", 1'b1, `PERIPH_SLOT_IRQ, s, $random(seed));
            end
            send("irq_claim", 1'b1, `PERIPH_SLOT_IRQ, 4, $random(seed));
            send("irq_claim", 1'b1, `PERIPH_SLOT_IRQ, 5, $unsigned($random(seed)) % 4);
            ext_irq = 2'($random(seed));
            drain();
            wait_cycles(3);
            exp_claim = u_mon.model_claim({ext_irq, 2'b00});
            read_word("irq_claim", `PERIPH_SLOT_IRQ, 7, d);
            if (d !== exp_claim) begin
                u_mon.report_mismatch("irq_claim", exp_claim, d);
            end
            if (irq !== (exp_claim != 0)) begin
                u_mon.report_mismatch("irq_claim irq_o", 32'(exp_claim != 0), 32'(irq));
            end
        end
        ext_irq = 2'b00;
        u_mon.finish_test("irq_claim");

        total_err = u_mon.err_cnt + UUT.u_chk.err_cnt;
        $display("tests %0d, passed %0d, errors %0d, assertion failures %0d",
                 u_mon.test_cnt, u_mon.pass_cnt, u_mon.err_cnt, UUT.u_chk.err_cnt);
        if (total_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
